//--- all.f
+incdir+.
rv_pkg.sv
rv_alu.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
rv_core_props.sv
tb_rv_core.sv

//--- run.sh
#!/bin/sh
# build the core and its testbench with verilator, run it, then scan the log
rm -f sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ns -f all.f \
    --top-module tb_rv_core -o tb_rv_core > build.log 2>&1 \
    || { cat build.log; echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_rv_core > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

//--- tb_rv_core.sv
////////////////////////////////////////
// testbench for the rv32i core, models instruction memory
// and checks every commit against a reference step
////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_params.svh"

module tb_rv_core;

    localparam int LIMIT = 50;   // cycles allowed for any wait

    logic                clk;
    logic                reset;
    logic                fetch_req;
    logic [`RV_XLEN-1:0] fetch_addr;
    rv_pkg::inst_u       fetch_data;
    logic                commit_valid;
    rv_pkg::commit_t     commit;

    logic [`RV_XLEN-1:0] model_regs [`RV_REG_COUNT];
    logic [`RV_XLEN-1:0] model_pc;
    logic [`RV_XLEN-1:0] pending [$];   // words sent, not yet committed
    integer              seed;
    int                  issued;
    int                  checked;
    int                  errors;
    int                  tests;
    int                  test_errors;   // error count when the test began

    rv_core dut0 (
        .clk          (clk),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [`RV_XLEN-1:0] rand32();
        return $random(seed);
    endfunction

    // offsets are byte offsets, bit 0 is dropped by the format
    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // expected commit for one word at pc, from the model registers
    function automatic rv_pkg::commit_t ref_step(input logic [31:0] w, input logic [31:0] pc);
        rv_pkg::commit_t c;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     imm_i;
        logic [31:0]     imm_b;
        logic            take;
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        c.pc      = pc;
        c.next_pc = pc + 32'd4;
        c.rd      = w[11:7];
        c.we      = 1'b0;
        c.wdata   = '0;
        case (w[6:0])
            `RV_OP_OP: begin
                c.we    = 1'b1;
                c.wdata = alu_ref(w[14:12], w[30], a, b);
            end
            `RV_OP_OPIMM: begin
                c.we    = 1'b1;
                c.wdata = alu_ref(w[14:12], w[14:12] == 3'b101 && w[30], a, imm_i);
            end
            `RV_OP_LUI: begin
                c.we    = 1'b1;
                c.wdata = {w[31:12], 12'h000};
            end
            `RV_OP_AUIPC: begin
                c.we    = 1'b1;
                c.wdata = pc + {w[31:12], 12'h000};
            end
            `RV_OP_JAL: begin
                c.we      = 1'b1;
                c.wdata   = pc + 32'd4;
                c.next_pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            `RV_OP_JALR: begin
                c.we      = 1'b1;
                c.wdata   = pc + 32'd4;
                c.next_pc = (a + imm_i) & ~32'd1;
            end
            `RV_OP_BRANCH: begin
                case (w[14:12])
                    3'b000:  take = a == b;
                    3'b001:  take = a != b;
                    3'b100:  take = $signed(a) < $signed(b);
                    3'b101:  take = $signed(a) >= $signed(b);
                    3'b110:  take = a < b;
                    3'b111:  take = a >= b;
                    default: take = 1'b0;
                endcase
                if (take) begin
                    c.next_pc = pc + imm_b;
                end
            end
            default: ;   // dropped opcodes only advance the pc
        endcase
        return c;
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: fetch_addr %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    // wdata only matters when a write is expected
    task automatic check_commit(input rv_pkg::commit_t got, input rv_pkg::commit_t exp);
        if (got.pc !== exp.pc || got.next_pc !== exp.next_pc || got.rd !== exp.rd
                || got.we !== exp.we || (exp.we && got.wdata !== exp.wdata)) begin
            $display("FAIL %0t: commit pc %h next %h rd %0d we %b wdata %h", $time,
                     got.pc, got.next_pc, got.rd, got.we, got.wdata);
            $display("    expected pc %h next %h rd %0d we %b wdata %h",
                     exp.pc, exp.next_pc, exp.rd, exp.we, exp.wdata);
            errors++;
        end
    endtask

    task automatic abort(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_fetch();
        int n;
        n = 0;
        while (!fetch_req && n < LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!fetch_req) begin
            abort("timeout waiting for fetch_req");
        end
    endtask

    // memory answers in the cycle after the request
    task automatic send(input logic [`RV_XLEN-1:0] word);
        wait_fetch();
        @(posedge clk);
        #1;
        fetch_data = word;
        pending.push_back(word);
        issued++;
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [`RV_XLEN-1:0] value);
        logic [`RV_XLEN-1:0] hi;
        hi = value + 32'h800;   // addi sign extends the low part
        send({hi[31:12], rd, `RV_OP_LUI});
        send({value[11:0], rd, 3'b000, rd, `RV_OP_OPIMM});
    endtask

    task automatic end_test(input string name);
        int n;
        n = 0;
        while (checked != issued && n < LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (checked != issued) begin
            abort("timeout waiting for the last commits of a test");
        end else begin
            tests++;
            $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
            test_errors = errors;
        end
    endtask

    initial begin : compare
        rv_pkg::commit_t     exp;
        logic [`RV_XLEN-1:0] word;
        int                  n;
        forever begin
            @(negedge clk);
            if (pending.size() != 0) begin
                n = 0;
                while (!commit_valid && n < LIMIT) begin
                    @(negedge clk);
                    n++;
                end
                if (!commit_valid) begin
                    abort("timeout waiting for commit_valid");
                end else begin
                    word = pending.pop_front();
                    exp  = ref_step(word, model_pc);
                    check_pc(fetch_addr, model_pc);
                    check_commit(commit, exp);
                    if (exp.we && exp.rd != '0) begin
                        model_regs[exp.rd] = exp.wdata;
                    end
                    model_pc = exp.next_pc;
                    checked++;
                end
            end else if (commit_valid) begin
                abort("commit_valid seen with no instruction fetched");
            end
        end
    end

    initial begin : stimulus
        logic [`RV_XLEN-1:0] r;
        seed        = 32'hdde2_1c46;
        reset       = 1'b1;
        fetch_data  = '0;
        issued      = 0;
        checked     = 0;
        errors      = 0;
        tests       = 0;
        test_errors = 0;
        model_pc    = `RV_RESET_PC;
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end

        repeat (8) begin
            @(posedge clk);
            #1;
            check_bit(fetch_req, 1'b0, "fetch_req in reset");
            check_bit(commit_valid, 1'b0, "commit_valid in reset");
        end
        reset = 1'b0;
        wait_fetch();
        check_pc(fetch_addr, `RV_RESET_PC);
        send(32'h0000_0013);   // nop
        end_test("reset");

        load_reg(5'd1, 32'h8000_0000);
        load_reg(5'd2, 32'h7fff_ffff);
        load_reg(5'd3, 32'hffff_ffff);
        load_reg(5'd4, 32'h0000_0001);
        load_reg(5'd5, rand32());
        load_reg(5'd6, rand32());
        send({7'h20, 5'd1, 5'd4, 3'b000, 5'd8, `RV_OP_OP});    // sub x8, x4, x1
        send({7'h20, 5'd4, 5'd1, 3'b101, 5'd9, `RV_OP_OP});    // sra x9, x1, x4
        send({12'h41f, 5'd3, 3'b101, 5'd10, `RV_OP_OPIMM});    // srai x10, x3, 31
        send({7'h00, 5'd3, 5'd4, 3'b011, 5'd11, `RV_OP_OP});   // sltu x11, x4, x3
        send({7'h00, 5'd4, 5'd3, 3'b011, 5'd12, `RV_OP_OP});   // sltu x12, x3, x4
        send({7'h00, 5'd2, 5'd1, 3'b010, 5'd13, `RV_OP_OP});   // slt x13, x1, x2
        repeat (40) begin
            r = rand32();
            // registers x0..x15 only, so values get reused
            if (r[0]) begin
                send({1'b0, r[30], 5'b0, 1'b0, r[23:20], 1'b0, r[18:15], r[14:12],
                      1'b0, r[10:7], `RV_OP_OP});
            end else begin
                send({r[31:20], 1'b0, r[18:15], r[14:12], 1'b0, r[10:7], `RV_OP_OPIMM});
            end
        end
        end_test("alu");

        repeat (6) begin
            r = rand32();
            send({r[31:12], 1'b0, r[10:7], r[5] ? `RV_OP_LUI : `RV_OP_AUIPC});
        end
        end_test("upper");

        load_reg(5'd1, 32'hffff_fff0);   // -16, unsigned larger than 5
        load_reg(5'd2, 32'd5);
        load_reg(5'd3, 32'd5);
        for (int c = 0; c < 8; c++) begin
            if (c != 2 && c != 3) begin
                r = rand32();
                send(enc_b(3'(c), 5'd2, 5'd3, r[12:0]));
                send(enc_b(3'(c), 5'd1, 5'd2, r[25:13]));
                send(enc_b(3'(c), 5'd2, 5'd1, {r[31:26], r[6:0]}));
            end
        end
        end_test("branch");

        r = rand32();
        send(enc_j(r[20:0], 5'd1));
        send(enc_j(r[31:11], 5'd0));   // link to x0 is discarded
        load_reg(5'd2, 32'h8000_1001);
        send({12'h010, 5'd2, 3'b000, 5'd5, `RV_OP_JALR});   // odd sum
        send({12'hff0, 5'd2, 3'b000, 5'd2, `RV_OP_JALR});   // rd same as rs1
        send({12'd123, 5'd3, 3'b000, 5'd0, `RV_OP_OPIMM});  // addi x0, x3, 123
        send({7'h00, 5'd0, 5'd0, 3'b000, 5'd7, `RV_OP_OP}); // add x7, x0, x0
        end_test("jump");

        repeat (8) begin
            r = rand32();
            case (r[1:0])
                2'd0:    send({r[31:7], 7'b0000011});   // load
                2'd1:    send({r[31:7], 7'b0100011});   // store
                2'd2:    send({r[31:7], 7'b1110011});   // system
                default: send({r[31:7], 7'b0001111});   // fence
            endcase
        end
        // read every low register back through add
        for (int i = 1; i < 8; i++) begin
            send({7'h00, 5'd0, 5'(i), 3'b000, 5'(i), `RV_OP_OP});
        end
        end_test("dropped");

        $display("tests %0d, commits checked %0d, errors %0d", tests, checked, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- rv_core_props.sv
////////////////////////////////////////
// fetch and commit timing checks
// bound into every rv_core instance
////////////////////////////////////////
`timescale 1ns/1ns

module rv_core_props (
    input logic            clk,
    input logic            reset,
    input logic            fetch_req,
    input logic            commit_valid,
    input rv_pkg::commit_t commit
);

    // the word arrives one cycle after the request
    req_then_commit: assert property (@(posedge clk) disable iff (reset)
        fetch_req |=> commit_valid)
        else $error("commit_valid did not follow fetch_req");

    commit_after_req: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> $past(fetch_req))
        else $error("commit_valid without a request the cycle before");

    never_both: assert property (@(posedge clk) disable iff (reset)
        !(fetch_req && commit_valid))
        else $error("fetch_req and commit_valid high together");

    aligned_next_pc: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> !commit.next_pc[0])   // pc stays even
        else $error("odd next_pc in commit");

endmodule

bind rv_core rv_core_props props0 (
    .clk          (clk),
    .reset        (reset),
    .fetch_req    (fetch_req),
    .commit_valid (commit_valid),
    .commit       (commit)
);

//--- rv_core.sv
////////////////////////////////////////
// rv32i core top, two cycles per instruction
// instruction memory sits outside with one-cycle latency
////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_core (
    input  logic                clk,
    input  logic                reset,
    output logic                fetch_req,
    output logic [`RV_XLEN-1:0] fetch_addr,
    input  rv_pkg::inst_u       fetch_data,
    output logic                commit_valid,
    output rv_pkg::commit_t     commit
);

    rv_pkg::dec_ctrl_t   ctrl;
    rv_pkg::redirect_t   redirect;
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;

    // fetch_addr doubles as the pc seen by execute
    rv_fetch u_fetch (
        .clk          (clk),
        .reset        (reset),
        .redirect     (redirect),
        .pc           (fetch_addr),
        .fetch_req    (fetch_req),
        .commit_valid (commit_valid)
    );

    rv_decode u_decode (
        .inst (fetch_data),
        .ctrl (ctrl)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .rs1    (ctrl.rs1),
        .rs2    (ctrl.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wr     (commit),
        .wr_en  (commit_valid)   // write lands at the end of wait
    );

    rv_execute u_execute (
        .ctrl     (ctrl),
        .pc       (fetch_addr),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .redirect (redirect),
        .commit   (commit)
    );

endmodule

//--- rv_execute.sv
////////////////////////////////////////
// operand select, branch and jump resolution, writeback
// result leaves as one commit record
////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_execute (
    input  rv_pkg::dec_ctrl_t   ctrl,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rdata1,
    input  logic [`RV_XLEN-1:0] rdata2,
    output rv_pkg::redirect_t   redirect,
    output rv_pkg::commit_t     commit
);

    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] link;       // pc + 4
    logic                br_cond;
    logic                taken;
    logic [`RV_XLEN-1:0] target;
    logic                we;

    rv_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    assign link = pc + `RV_XLEN'd4;

    always_comb begin
        case (ctrl.cls)
            rv_pkg::CLS_R: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
            rv_pkg::CLS_I, rv_pkg::CLS_JALR: begin
                alu_a = rdata1;
                alu_b = ctrl.imm;
            end
            rv_pkg::CLS_LUI: begin
                alu_a = '0;
                alu_b = ctrl.imm;
            end
            default: begin      // auipc, jal, branches, and the unkept ones
                alu_a = pc;
                alu_b = ctrl.imm;
            end
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (ctrl.funct3)
            3'b000:  br_cond = (rdata1 == rdata2);
            3'b001:  br_cond = (rdata1 != rdata2);
            3'b100:  br_cond = ($signed(rdata1) < $signed(rdata2));
            3'b101:  br_cond = ($signed(rdata1) >= $signed(rdata2));
            3'b110:  br_cond = (rdata1 < rdata2);
            3'b111:  br_cond = (rdata1 >= rdata2);
            default: br_cond = 1'b0;
        endcase
    end

    assign taken = (ctrl.cls == rv_pkg::CLS_JAL) || (ctrl.cls == rv_pkg::CLS_JALR)
                 || (ctrl.cls == rv_pkg::CLS_B && br_cond);

    // jalr drops bit 0 of the sum
    assign target = (ctrl.cls == rv_pkg::CLS_JALR) ? {alu_result[`RV_XLEN-1:1], 1'b0}
                                                   : alu_result;

    assign we = (ctrl.cls != rv_pkg::CLS_B) && (ctrl.cls != rv_pkg::CLS_NONE);

    assign redirect.target = target;
    assign redirect.taken  = taken;

    always_comb begin
        commit.pc      = pc;
        commit.next_pc = taken ? target : link;
        commit.rd      = ctrl.rd;
        commit.we      = we;
        // jumps write the return address
        if (ctrl.cls == rv_pkg::CLS_JAL || ctrl.cls == rv_pkg::CLS_JALR) begin
            commit.wdata = link;
        end else begin
            commit.wdata = alu_result;
        end
    end

endmodule

//--- rv_regfile.sv
////////////////////////////////////////
// 32 x 32 general register file
// two combinational reads, one write at commit
////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`RV_REG_AW-1:0] rs1,
    input  logic [`RV_REG_AW-1:0] rs2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2,
    input  rv_pkg::commit_t       wr,
    input  logic                  wr_en
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr.we && wr.rd != '0) begin   // x0 never written
            regs[wr.rd] <= wr.wdata;
        end
    end

    // x0 keeps its reset zero
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

//--- rv_decode.sv
////////////////////////////////////////
// instruction decode into a control record
// purely combinational, fed by the fetched word
////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_decode (
    input  rv_pkg::inst_u     inst,
    output rv_pkg::dec_ctrl_t ctrl
);

    logic [`RV_XLEN-1:0] w;        // raw bits for the scattered immediates
    rv_pkg::inst_class_t cls;
    rv_pkg::alu_op_t     alu_op;
    logic [`RV_XLEN-1:0] imm;

    assign w = inst;

    always_comb begin
        case (inst.r.opcode)
            `RV_OP_OP:     cls = rv_pkg::CLS_R;
            `RV_OP_OPIMM:  cls = rv_pkg::CLS_I;
            `RV_OP_JALR:   cls = rv_pkg::CLS_JALR;
            `RV_OP_LUI:    cls = rv_pkg::CLS_LUI;
            `RV_OP_AUIPC:  cls = rv_pkg::CLS_AUIPC;
            `RV_OP_JAL:    cls = rv_pkg::CLS_JAL;
            `RV_OP_BRANCH: cls = rv_pkg::CLS_B;
            default:       cls = rv_pkg::CLS_NONE;   // loads, stores, system
        endcase
    end

    // immediate per class
    always_comb begin
        case (cls)
            rv_pkg::CLS_I, rv_pkg::CLS_JALR:
                imm = {{20{inst.i.imm12[11]}}, inst.i.imm12};
            rv_pkg::CLS_B:
                imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            rv_pkg::CLS_LUI, rv_pkg::CLS_AUIPC:
                imm = {w[31:12], 12'b0};
            rv_pkg::CLS_JAL:
                imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    always_comb begin
        alu_op = rv_pkg::ALU_ADD;   // jumps, branches and upper imms add
        if (cls == rv_pkg::CLS_R || cls == rv_pkg::CLS_I) begin
            case (inst.r.funct3)
                3'b000: begin
                    // addi has no subtract form
                    if (cls == rv_pkg::CLS_R && inst.r.funct7[5]) begin
                        alu_op = rv_pkg::ALU_SUB;
                    end
                end
                3'b001: alu_op = rv_pkg::ALU_SLL;
                3'b010: alu_op = rv_pkg::ALU_SLT;
                3'b011: alu_op = rv_pkg::ALU_SLTU;
                3'b100: alu_op = rv_pkg::ALU_XOR;
                3'b101: alu_op = inst.r.funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110: alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

    always_comb begin
        ctrl.cls    = cls;
        ctrl.alu_op = alu_op;
        ctrl.funct3 = inst.r.funct3;
        ctrl.rd     = inst.r.rd;
        ctrl.rs1    = inst.r.rs1;
        ctrl.rs2    = inst.r.rs2;   // meaningless outside R and B, never written back
        ctrl.imm    = imm;
    end

endmodule

//--- rv_fetch.sv
////////////////////////////////////////
// pc register and two-state fetch sequencer
// idle requests the word, wait commits it
////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_fetch (
    input  logic                clk,
    input  logic                reset,
    input  rv_pkg::redirect_t   redirect,
    output logic [`RV_XLEN-1:0] pc,
    output logic                fetch_req,
    output logic                commit_valid
);

    logic                run;        // set one cycle after reset drops
    logic                wait_q;     // 0 idle, 1 wait
    logic [`RV_XLEN-1:0] next_pc;

    // sequential or redirected target
    assign next_pc = redirect.taken ? redirect.target : pc + `RV_XLEN'd4;

    assign fetch_req    = run & ~wait_q;
    assign commit_valid = wait_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            run    <= 1'b0;
            wait_q <= 1'b0;
            pc     <= `RV_RESET_PC;
        end else begin
            run <= 1'b1;
            if (fetch_req) begin
                wait_q <= 1'b1;
            end else if (wait_q) begin
                // instruction commits at this edge
                wait_q <= 1'b0;
                pc     <= next_pc;
            end
        end
    end

endmodule

//--- rv_alu.sv
////////////////////////////////////////
// integer ALU for the rv32i base set
////////////////////////////////////////
`timescale 1ns/1ns
`include "rv_params.svh"

module rv_alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_pkg::alu_op_t     op,
    output logic [`RV_XLEN-1:0] result
);

    logic [4:0] shamt;   // only the low five bits shift

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:  result = a + b;
            rv_pkg::ALU_SUB:  result = a - b;
            rv_pkg::ALU_SLL:  result = a << shamt;
            rv_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU: result = {31'b0, a < b};
            rv_pkg::ALU_XOR:  result = a ^ b;
            rv_pkg::ALU_SRL:  result = a >> shamt;
            rv_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            rv_pkg::ALU_OR:   result = a | b;
            rv_pkg::ALU_AND:  result = a & b;
            default:          result = '0;   // unused encodings
        endcase
    end

endmodule

//--- rv_pkg.sv
////////////////////////////////////////
// shared types of the rv32i core
// referenced by scoped name from each block
////////////////////////////////////////
`include "rv_params.svh"

package rv_pkg;

    // instruction classes that the core keeps
    typedef enum logic [2:0] {
        CLS_R,
        CLS_I,
        CLS_JALR,
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_B,
        CLS_NONE    // anything not executed
    } inst_class_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // register format view
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    // immediate format view
    typedef struct packed {
        logic [11:0]           imm12;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } inst_i_t;

    // one instruction word, two decodings
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef struct packed {
        inst_class_t           cls;
        alu_op_t               alu_op;
        logic [2:0]            funct3;   // branch condition select
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_XLEN-1:0]   imm;      // sign extended for the class
    } dec_ctrl_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] target;
        logic                taken;
    } redirect_t;

    // what one instruction leaves behind
    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   next_pc;
        logic [`RV_REG_AW-1:0] rd;
        logic                  we;
        logic [`RV_XLEN-1:0]   wdata;
    } commit_t;

endpackage

//--- rv_params.svh
////////////////////////////////////////
// core-wide widths, reset pc and kept opcodes
// include wherever a width or opcode value is needed
////////////////////////////////////////
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_XLEN      32
`define RV_REG_COUNT 32
`define RV_REG_AW    5
`define RV_RESET_PC  32'h8000_0000   // first fetch address

// major opcodes that the core executes
`define RV_OP_OP     7'b0110011
`define RV_OP_OPIMM  7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011

`endif
